// File: logic/mem_wb_consts.svh
`ifndef MEM_WB_CONSTS_SVH
`define MEM_WB_CONSTS_SVH

// Datapath widths
`define DATA_WIDTH       32  // Register file and memory word
`define DMEM_ADDR_WIDTH  11  // Byte address into data memory
`define REG_ADDR_WIDTH   5   // Register index x0..x31

// Data memory geometry
`define DMEM_WORDS       512 // 2 KiB of 32-bit words

// Store width codes from the decoder
`define ST_BYTE          2'd0 // sb
`define ST_HALF          2'd1 // sh
`define ST_WORD          2'd2 // sw

// Write-back source codes
`define RS_ALU           2'd0 // ALU or immediate result
`define RS_MEM           2'd1 // Loaded word
`define RS_PC4           2'd2 // Link address for jal/jalr

// Code 3 is unused for both store type and result source

`endif

// File: logic/mem_wb_pkg.sv
`include "mem_wb_consts.svh"

package mem_wb_pkg;

  // Full register or memory word
  typedef logic [`DATA_WIDTH-1:0] data_t;

  // Byte address into data memory
  typedef logic [`DMEM_ADDR_WIDTH-1:0] dmem_addr_t;

  // Link address sized like the memory address
  typedef logic [`DMEM_ADDR_WIDTH-1:0] pc4_t;

  // Destination register index
  typedef logic [`REG_ADDR_WIDTH-1:0] reg_addr_t;

  // Store width, see ST_* codes
  typedef logic [1:0] store_type_t;

  // Write-back mux select, see RS_* codes
  typedef logic [1:0] result_src_t;

endpackage

// File: logic/dmem_if.sv
`timescale 1ns/1ps

// Request and read-data path between the MEM stage and data memory
interface dmem_if import mem_wb_pkg::*; ();

  logic        req;       // Instruction accepted this cycle
  logic        we;        // Accepted instruction is a store
  dmem_addr_t  addr;      // Byte address
  data_t       wdata;     // Unshifted store data from rs2
  store_type_t storetype; // Byte, half or word
  data_t       rdata;     // Registered read word

  // MEM stage side
  modport requester (
    output req,
    output we,
    output addr,
    output wdata,
    output storetype,
    input  rdata
  );

  // Memory array side
  modport responder (
    input  req,
    input  we,
    input  addr,
    input  wdata,
    input  storetype,
    output rdata
  );

endinterface

// File: logic/memory_stage.sv
`timescale 1ns/1ps
`include "mem_wb_consts.svh"

module memory_stage import mem_wb_pkg::*; (
  input  logic         i_clk,
  input  logic         i_rst_n,
  // From EX stage
  input  logic         i_valid_m,
  input  logic         i_regwrite_m,
  input  logic         i_memwrite_m,
  input  result_src_t  i_resultsrc_m,
  input  data_t        i_alu_result_m,
  input  data_t        i_write_data_m,
  input  store_type_t  i_storetype_m,
  input  reg_addr_t    i_rd_addr_m,
  input  pc4_t         i_pc4_m,
  output logic         o_ready_m,
  // To WB stage
  input  logic         i_ready_w,
  output logic         o_valid_w,
  output logic         o_regwrite_w,
  output result_src_t  o_resultsrc_w,
  output data_t        o_alu_result_w,
  output reg_addr_t    o_rd_addr_w,
  output pc4_t         o_pc4_w,
  // Data memory request
  dmem_if.requester    o_dmem
);

  logic valid_q; // MEM/WB register holds a result
  logic accept;  // Input handshake completes this edge

  // Free slot, or the held result leaves on this edge
  assign o_ready_m = !valid_q || i_ready_w;
  assign accept    = i_valid_m && o_ready_m;

  // Memory request straight from the incoming instruction
  assign o_dmem.req       = accept;
  assign o_dmem.we        = i_memwrite_m;
  assign o_dmem.addr      = i_alu_result_m[`DMEM_ADDR_WIDTH-1:0]; // Low ALU bits
  assign o_dmem.wdata     = i_write_data_m;
  assign o_dmem.storetype = i_storetype_m;

  // Valid bit and control fields
  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      valid_q       <= 1'b0;
      o_regwrite_w  <= 1'b0;
      o_resultsrc_w <= `RS_ALU;
    end else if (accept) begin
      valid_q       <= 1'b1; // New result replaces or fills the slot
      o_regwrite_w  <= i_regwrite_m;
      o_resultsrc_w <= i_resultsrc_m;
    end else if (i_ready_w) begin
      valid_q <= 1'b0; // Consumed with nothing behind it
    end
  end

  // Payload fields
  always_ff @(posedge i_clk) begin
    if (accept) begin
      o_alu_result_w <= i_alu_result_m;
      o_rd_addr_w    <= i_rd_addr_m;
      o_pc4_w        <= i_pc4_m;
    end
  end

  assign o_valid_w = valid_q;

  // Upstream holds its instruction while stalled
  a_stall_stable: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    (i_valid_m && !o_ready_m) |=> (i_valid_m && $stable({i_regwrite_m, i_memwrite_m,
      i_resultsrc_m, i_alu_result_m, i_write_data_m, i_storetype_m, i_rd_addr_m, i_pc4_m})))
    else $error("memory_stage: input changed while stalled");

  // Half stores on even addresses only
  a_half_align: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    (accept && i_memwrite_m && i_storetype_m == `ST_HALF) |-> !i_alu_result_m[0])
    else $error("memory_stage: misaligned half store");

  // Word stores on word boundaries only
  a_word_align: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    (accept && i_memwrite_m && i_storetype_m == `ST_WORD) |-> (i_alu_result_m[1:0] == 2'b00))
    else $error("memory_stage: misaligned word store");

endmodule

// File: logic/data_memory.sv
`timescale 1ns/1ps
`include "mem_wb_consts.svh"

module data_memory import mem_wb_pkg::*; (
  input  logic        i_clk,
  input  logic        i_rst_n,
  dmem_if.responder   i_dmem
);

  data_t mem [`DMEM_WORDS]; // Word storage

  logic [`DMEM_ADDR_WIDTH-3:0] word_idx; // Word select from addr[10:2]
  logic [1:0]                  byte_off; // Lane within the word
  logic [3:0]                  lane_en;  // Byte write enables
  data_t                       wdata_rep; // Store data copied across lanes
  data_t                       rdata_q;

  assign word_idx = i_dmem.addr[`DMEM_ADDR_WIDTH-1:2];
  assign byte_off = i_dmem.addr[1:0];

  // Lane enables by width and offset
  always_comb begin
    case (i_dmem.storetype)
      `ST_BYTE: lane_en = 4'b0001 << byte_off;
      `ST_HALF: lane_en = byte_off[1] ? 4'b1100 : 4'b0011; // Upper or lower half
      `ST_WORD: lane_en = 4'b1111;
      default:  lane_en = 4'b0000; // Unused code writes nothing
    endcase
  end

  // Replicate narrow data so every lane sees the right byte
  always_comb begin
    case (i_dmem.storetype)
      `ST_BYTE: wdata_rep = {4{i_dmem.wdata[7:0]}};
      `ST_HALF: wdata_rep = {2{i_dmem.wdata[15:0]}};
      default:  wdata_rep = i_dmem.wdata;
    endcase
  end

  // Store with per-byte enables
  always_ff @(posedge i_clk) begin
    if (i_dmem.req && i_dmem.we) begin
      for (int lane = 0; lane < 4; lane++) begin
        if (lane_en[lane]) begin
          mem[word_idx][8*lane +: 8] <= wdata_rep[8*lane +: 8];
        end
      end
    end
  end

  // Synchronous word read
  // Held between requests so stalled loads keep their data
  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      rdata_q <= '0;
    end else if (i_dmem.req && !i_dmem.we) begin
      rdata_q <= mem[word_idx]; // Whole aligned word
    end
  end

  assign i_dmem.rdata = rdata_q;

  // A store carries one of the three width codes
  a_store_type: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    (i_dmem.req && i_dmem.we) |-> (i_dmem.storetype inside {`ST_BYTE, `ST_HALF, `ST_WORD}))
    else $error("data_memory: illegal store type");

endmodule

// File: logic/writeback_select.sv
`timescale 1ns/1ps
`include "mem_wb_consts.svh"

module writeback_select import mem_wb_pkg::*; (
  input  logic        i_valid_w,
  input  logic        i_regwrite_w,
  input  result_src_t i_resultsrc_w,
  input  data_t       i_alu_result_w,
  input  data_t       i_read_data_w,
  input  pc4_t        i_pc4_w,
  input  reg_addr_t   i_rd_addr_w,
  // Toward the register file
  output data_t       o_result_w,
  output logic        o_regwrite_w,
  output reg_addr_t   o_rd_addr_w
);

  data_t pc4_ext; // Link address widened to a full word

  assign pc4_ext = {{(`DATA_WIDTH-`DMEM_ADDR_WIDTH){1'b0}}, i_pc4_w};

  // Result mux
  always_comb begin
    case (i_resultsrc_w)
      `RS_ALU: o_result_w = i_alu_result_w;
      `RS_MEM: o_result_w = i_read_data_w;  // Loaded word
      `RS_PC4: o_result_w = pc4_ext;        // jal/jalr link
      default: o_result_w = '0;
    endcase
  end

  // x0 stays zero, and a bubble writes nothing
  assign o_regwrite_w = i_valid_w && i_regwrite_w && (i_rd_addr_w != '0);
  assign o_rd_addr_w  = i_rd_addr_w;

  // Decoder never hands a live result the unused source code
  always_comb begin
    if (i_valid_w) begin
      a_src_legal: assert (i_resultsrc_w inside {`RS_ALU, `RS_MEM, `RS_PC4})
        else $error("writeback_select: illegal result source");
    end
  end

endmodule

// File: logic/mem_wb_top.sv
`timescale 1ns/1ps

module mem_wb_top import mem_wb_pkg::*; (
  input  logic        i_clk,
  input  logic        i_rst_n,
  // Upstream instruction
  input  logic        i_valid_m,
  input  logic        i_regwrite_m,
  input  logic        i_memwrite_m,
  input  result_src_t i_resultsrc_m,
  input  data_t       i_alu_result_m,
  input  data_t       i_write_data_m,
  input  store_type_t i_storetype_m,
  input  reg_addr_t   i_rd_addr_m,
  input  pc4_t        i_pc4_m,
  output logic        o_ready_m,
  // Register file write
  input  logic        i_ready_w,
  output logic        o_valid_w,
  output logic        o_regwrite_w,
  output reg_addr_t   o_rd_addr_w,
  output data_t       o_result_w
);

  // MEM/WB register contents
  logic        regwrite_q;
  result_src_t resultsrc_q;
  data_t       alu_result_q;
  reg_addr_t   rd_addr_q;
  pc4_t        pc4_q;

  dmem_if dmem_bus (); // Stage to memory request path

  // Handshake and pipeline register
  memory_stage u_memory_stage (
    .i_clk          (i_clk),
    .i_rst_n        (i_rst_n),
    .i_valid_m      (i_valid_m),
    .i_regwrite_m   (i_regwrite_m),
    .i_memwrite_m   (i_memwrite_m),
    .i_resultsrc_m  (i_resultsrc_m),
    .i_alu_result_m (i_alu_result_m),
    .i_write_data_m (i_write_data_m),
    .i_storetype_m  (i_storetype_m),
    .i_rd_addr_m    (i_rd_addr_m),
    .i_pc4_m        (i_pc4_m),
    .o_ready_m      (o_ready_m),
    .i_ready_w      (i_ready_w),
    .o_valid_w      (o_valid_w),
    .o_regwrite_w   (regwrite_q),
    .o_resultsrc_w  (resultsrc_q),
    .o_alu_result_w (alu_result_q),
    .o_rd_addr_w    (rd_addr_q),
    .o_pc4_w        (pc4_q),
    .o_dmem         (dmem_bus.requester)
  );

  // Runs alongside the pipeline register
  data_memory u_data_memory (
    .i_clk   (i_clk),
    .i_rst_n (i_rst_n),
    .i_dmem  (dmem_bus.responder)
  );

  // Combinational write-back mux
  writeback_select u_writeback_select (
    .i_valid_w      (o_valid_w),
    .i_regwrite_w   (regwrite_q),
    .i_resultsrc_w  (resultsrc_q),
    .i_alu_result_w (alu_result_q),
    .i_read_data_w  (dmem_bus.rdata), // Lines up with the register output
    .i_pc4_w        (pc4_q),
    .i_rd_addr_w    (rd_addr_q),
    .o_result_w     (o_result_w),
    .o_regwrite_w   (o_regwrite_w),
    .o_rd_addr_w    (o_rd_addr_w)
  );

endmodule

// File: testbench/tb_mem_wb_top.sv
`timescale 1ns/1ps
`include "mem_wb_consts.svh"

module tb_mem_wb_top import mem_wb_pkg::*; ();

  localparam int NUM_FILL       = 64;                  // One word store per region word
  localparam int NUM_INSTR      = NUM_FILL + 400;      // Fill pass plus random mix
  localparam int TIMEOUT_CYCLES = 4 * NUM_INSTR + 100;
  localparam int REGION_BASE    = 'h200;               // Byte address of the test region
  localparam int REGION_BYTES   = 4 * NUM_FILL;

  // Expected write-back for one accepted instruction
  typedef struct packed {
    data_t     result;
    reg_addr_t rd;
    logic      regwrite;
  } exp_t;

  logic        i_clk;
  logic        i_rst_n;
  logic        i_valid_m;
  logic        i_regwrite_m;
  logic        i_memwrite_m;
  result_src_t i_resultsrc_m;
  data_t       i_alu_result_m;
  data_t       i_write_data_m;
  store_type_t i_storetype_m;
  reg_addr_t   i_rd_addr_m;
  pc4_t        i_pc4_m;
  logic        o_ready_m;
  logic        i_ready_w;
  logic        o_valid_w;
  logic        o_regwrite_w;
  reg_addr_t   o_rd_addr_w;
  data_t       o_result_w;

  integer     seed = 32'h961c;
  logic [7:0] model_mem [0:(1 << `DMEM_ADDR_WIDTH)-1]; // Byte image of data memory
  exp_t       exp_q [$];                               // Results in flight, oldest first
  int         issued;
  int         consumed;
  int         cycle_count;
  logic       hold;                                    // Stalled instruction stays on the inputs

  mem_wb_top dut_i (.*);

  initial begin
    i_clk = 1'b0;
    forever #20 i_clk = ~i_clk;
  end

  task automatic stop_on_error(input string msg);
    $display("%s", msg);
    $display("TB FAILED");
    $fatal(1, "Stopped at first error");
  endtask

  task automatic check_result(input data_t got, input data_t exp);
    if (got !== exp)
      stop_on_error($sformatf("Mismatch at %0t: result got %h expected %h", $time, got, exp));
  endtask

  task automatic check_rd(input reg_addr_t got, input reg_addr_t exp);
    if (got !== exp)
      stop_on_error($sformatf("Mismatch at %0t: rd got x%0d expected x%0d", $time, got, exp));
  endtask

  task automatic check_regwrite(input logic got, input logic exp);
    if (got !== exp)
      stop_on_error($sformatf("Mismatch at %0t: regwrite got %b expected %b", $time, got, exp));
  endtask

  task automatic check_ready(input logic got, input logic exp);
    if (got !== exp)
      stop_on_error($sformatf("Mismatch at %0t: o_ready_m got %b expected %b", $time, got, exp));
  endtask

  // Non-negative draw below n
  function automatic int rand_below(input int n);
    logic [31:0] r;
    r = $random(seed);
    return int'(r[30:0]) % n;
  endfunction

  // Put one instruction on the upstream inputs
  task automatic issue_instr(input int idx);
    int          kind;
    int          off;
    data_t       alu;
    logic        wr;
    logic        mw;
    result_src_t src;
    store_type_t st;
    reg_addr_t   rd;
    alu  = $random(seed);         // Upper bits are don't-care for memory ops
    rd   = reg_addr_t'(rand_below(32));
    if (rand_below(8) == 0) rd = '0; // Extra x0 traffic
    kind = (idx < NUM_FILL) ? 2 : rand_below(7);
    off  = (idx < NUM_FILL) ? 4 * idx : rand_below(REGION_BYTES);
    wr   = 1'b0;
    mw   = 1'b0;
    src  = `RS_ALU;
    st   = `ST_WORD;
    case (kind)
      0: begin
        mw = 1'b1;
        st = `ST_BYTE;
      end
      1: begin
        mw  = 1'b1;
        st  = `ST_HALF;
        off = off - (off % 2);
      end
      2: begin
        mw  = 1'b1;
        st  = `ST_WORD;
        off = off - (off % 4);
      end
      3, 6: begin                                        // Loads, any offset
        src = `RS_MEM;
        wr  = (rand_below(8) != 0);
      end
      4: wr = (rand_below(4) != 0);                      // ALU op
      default: begin                                     // jal/jalr
        src = `RS_PC4;
        wr  = 1'b1;
      end
    endcase
    if (kind <= 3 || kind == 6) alu[`DMEM_ADDR_WIDTH-1:0] = dmem_addr_t'(REGION_BASE + off);
    i_valid_m      <= 1'b1;
    i_regwrite_m   <= wr;
    i_memwrite_m   <= mw;
    i_resultsrc_m  <= src;
    i_alu_result_m <= alu;
    i_write_data_m <= $random(seed);
    i_storetype_m  <= st;
    i_rd_addr_m    <= rd;
    i_pc4_m        <= pc4_t'(rand_below(1 << `DMEM_ADDR_WIDTH));
  endtask

  // Update the byte model and queue the expected result
  task automatic record_accept();
    exp_t e;
    int   a;
    int   wa;
    a  = int'(i_alu_result_m[`DMEM_ADDR_WIDTH-1:0]);
    wa = a - (a % 4);                                    // Aligned word base
    if (i_memwrite_m) begin
      model_mem[a] = i_write_data_m[7:0];
      if (i_storetype_m != `ST_BYTE) model_mem[a+1] = i_write_data_m[15:8];
      if (i_storetype_m == `ST_WORD) begin
        model_mem[a+2] = i_write_data_m[23:16];
        model_mem[a+3] = i_write_data_m[31:24];
      end
    end
    case (i_resultsrc_m)
      `RS_MEM: e.result = {model_mem[wa+3], model_mem[wa+2], model_mem[wa+1], model_mem[wa]};
      `RS_PC4: e.result = data_t'(i_pc4_m);              // Zero-extended link
      default: e.result = i_alu_result_m;
    endcase
    e.rd       = i_rd_addr_m;
    e.regwrite = i_regwrite_m && (i_rd_addr_m != '0);    // x0 never written
    exp_q.push_back(e);
  endtask

  // Bound on run length
  always @(posedge i_clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES)
      stop_on_error($sformatf("Timeout after %0d cycles with %0d of %0d results seen",
                              cycle_count, consumed, NUM_INSTR));
  end

  initial begin
    cycle_count = 0;
    issued      = 0;
    consumed    = 0;
    hold        = 1'b0;
    i_rst_n        <= 1'b0;
    i_valid_m      <= 1'b0;
    i_regwrite_m   <= 1'b0;
    i_memwrite_m   <= 1'b0;
    i_resultsrc_m  <= `RS_ALU;
    i_alu_result_m <= '0;
    i_write_data_m <= '0;
    i_storetype_m  <= `ST_WORD;
    i_rd_addr_m    <= '0;
    i_pc4_m        <= '0;
    i_ready_w      <= 1'b1;
    repeat (2) @(posedge i_clk);
    i_rst_n <= 1'b1;

    while (consumed < NUM_INSTR) begin
      @(negedge i_clk);                                  // All DUT outputs settled here
      check_ready(o_ready_m, (exp_q.size() == 0) || i_ready_w); // Empty slot or draining
      if (o_valid_w) begin
        if (exp_q.size() == 0) stop_on_error("o_valid_w is high with no result pending");
        check_result(o_result_w, exp_q[0].result);       // Also checks stability while stalled
        check_rd(o_rd_addr_w, exp_q[0].rd);
        check_regwrite(o_regwrite_w, exp_q[0].regwrite);
        if (i_ready_w) begin
          void'(exp_q.pop_front());
          consumed++;
        end
      end else begin
        if (exp_q.size() != 0) stop_on_error("Accepted instruction did not show up on o_valid_w");
        check_regwrite(o_regwrite_w, 1'b0);
      end
      if (i_valid_m && o_ready_m) record_accept();
      hold = i_valid_m && !o_ready_m;

      @(posedge i_clk);
      i_ready_w <= (rand_below(4) != 0);                 // Random back-pressure
      if (!hold) begin
        if (issued < NUM_INSTR && rand_below(5) != 0) begin
          issue_instr(issued);
          issued++;
        end else begin
          i_valid_m <= 1'b0;                             // Bubble
        end
      end
    end

    @(negedge i_clk);                                    // Last result has left the register
    if (!o_valid_w && exp_q.size() == 0) begin
      $display("TB PASSED");
      $finish;
    end else begin
      stop_on_error("A result was still valid after the last one was consumed");
    end
  end

endmodule

// File: mem_wb.f
+incdir+logic
logic/mem_wb_pkg.sv
logic/dmem_if.sv
logic/memory_stage.sv
logic/data_memory.sv
logic/writeback_select.sv
logic/mem_wb_top.sv
testbench/tb_mem_wb_top.sv

// File: Makefile
TOP   = tb_mem_wb_top
FLIST = mem_wb.f

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --assert -f $(FLIST) --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f $(FLIST) --top-module $(TOP) \
		-Mdir obj_dir -o sim_$(TOP)
	-./obj_dir/sim_$(TOP) > sim.log 2>&1
	cat sim.log
	grep -q "TB PASSED" sim.log

clean:
	rm -rf obj_dir sim.log
